// ==== sim.f ====
mbox_pkg.sv
mbox_sram.sv
mbox_data_path.sv
mbox_fsm.sv
mbox_regs.sv
mbox_top.sv
tb_clk_gen.sv
mbox_tb.sv

// ==== mbox_tb.sv ====
/* directed testbench for the mailbox; walks lock, transfer, ownership, response
   and unlock sequences through the shared register port of the top level */
module mbox_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_W         = 32;
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int HOLD_LIMIT     = 8;

    logic                            clk;
    logic                            rst_b;
    logic                            req_dv;
    logic                            req_write;
    logic [mbox_pkg::REG_ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0]               req_wdata;
    logic                            req_soc;
    logic [mbox_pkg::USER_W-1:0]     req_user;
    logic [DATA_W-1:0]               rdata;
    logic                            req_hold;
    logic                            mbox_error;
    logic                            uc_mbox_data_avail;
    logic                            soc_mbox_data_avail;

    logic [31:0] lcg_state = 32'he161b6e4;
    int          cycle_count = 0;

    tb_clk_gen i_tb_clk_gen (
        .clk   (clk),
        .rst_b (rst_b)
    );

    mbox_top i_mbox_top (
        .clk                 (clk),
        .rst_b               (rst_b),
        .req_dv              (req_dv),
        .req_write           (req_write),
        .req_addr            (req_addr),
        .req_wdata           (req_wdata),
        .req_soc             (req_soc),
        .req_user            (req_user),
        .rdata               (rdata),
        .req_hold            (req_hold),
        .mbox_error          (mbox_error),
        .uc_mbox_data_avail  (uc_mbox_data_avail),
        .soc_mbox_data_avail (soc_mbox_data_avail)
    );

    // the whole run is about a hundred cycles, anything near the limit is a hang
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    // numerical recipes constants, full 32 bit period
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        lcg_step = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // status layout: command status, then the state field, then soc ownership
    function automatic logic [31:0] status_word(input logic [2:0] state,
                                                input logic       soc_lock,
                                                input logic [1:0] status);
        status_word = '0;
        status_word[1:0] = status;
        status_word[mbox_pkg::STATUS_STATE_LSB +: 3] = state;
        status_word[mbox_pkg::STATUS_STATE_LSB + 3] = soc_lock;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // starts and ends 2 ns after a rising edge, samples at the falling edge
    task automatic bus_access(input logic soc, input logic [mbox_pkg::USER_W-1:0] user,
                              input logic write, input logic [mbox_pkg::REG_ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rd,
                              output logic err, output int holds);
        holds     = 0;
        req_dv    = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_soc   = soc;
        req_user  = user;
        @(negedge clk);
        // a stalled request stays on the bus unchanged until it is taken
        while (req_hold) begin
            holds++;
            assert (holds <= HOLD_LIMIT) else begin
                $display("ERROR: req_hold stayed high for more than %0d cycles", HOLD_LIMIT);
                $display("Testbench failed");
                $fatal(1);
            end
            @(negedge clk);
        end
        rd  = rdata;
        err = mbox_error;
        @(posedge clk);
        #2;
        req_dv    = 1'b0;
        req_write = 1'b0;
    endtask

    task automatic reg_write(input logic soc, input logic [mbox_pkg::USER_W-1:0] user,
                             input logic [mbox_pkg::REG_ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] rd;
        logic              err;
        int                holds;
        bus_access(soc, user, 1'b1, addr, wdata, rd, err, holds);
        check_value("mbox_error", 0, err);
    endtask

    task automatic reg_read(input logic soc, input logic [mbox_pkg::USER_W-1:0] user,
                            input logic [mbox_pkg::REG_ADDR_W-1:0] addr,
                            output logic [DATA_W-1:0] rd, output int holds);
        logic err;
        bus_access(soc, user, 1'b0, addr, '0, rd, err, holds);
        check_value("mbox_error", 0, err);
    endtask

    // clearing execute lands in idle one edge after the write
    task automatic wait_idle();
        int n;
        n = 0;
        while (uc_mbox_data_avail || soc_mbox_data_avail) begin
            n++;
            assert (n <= 4) else begin
                $display("ERROR: mailbox did not return to idle after execute was cleared");
                $display("Testbench failed");
                $fatal(1);
            end
            @(posedge clk);
            #2;
        end
    endtask

    task automatic reset_and_lock();
        logic [DATA_W-1:0] rd;
        int                holds;
        check_value("uc_mbox_data_avail", 0, uc_mbox_data_avail);
        check_value("soc_mbox_data_avail", 0, soc_mbox_data_avail);
        reg_read(1'b0, 8'd0, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status.state", mbox_pkg::MBOX_IDLE, rd[mbox_pkg::STATUS_STATE_LSB +: 3]);
        // the first read takes the lock and still returns the old value
        reg_read(1'b0, 8'd0, mbox_pkg::REG_LOCK, rd, holds);
        check_value("lock", 0, rd);
        reg_read(1'b0, 8'd0, mbox_pkg::REG_LOCK, rd, holds);
        check_value("lock", 1, rd);
        reg_read(1'b0, 8'd0, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status", status_word(mbox_pkg::MBOX_RDY_FOR_CMD, 1'b0,
                                          mbox_pkg::CMD_BUSY), rd);
    endtask

    task automatic uc_to_soc_transfer();
        logic [DATA_W-1:0] words [8];
        logic [DATA_W-1:0] rd;
        int                holds;
        reg_write(1'b0, 8'd0, mbox_pkg::REG_CMD, 32'h0000_00a5);
        reg_write(1'b0, 8'd0, mbox_pkg::REG_DLEN, 32'd32);
        for (int i = 0; i < 8; i++) begin
            lcg_state = lcg_step(lcg_state);
            words[i] = lcg_state;
            reg_write(1'b0, 8'd0, mbox_pkg::REG_DATAIN, words[i]);
        end
        reg_write(1'b0, 8'd0, mbox_pkg::REG_EXECUTE, 32'd1);
        check_value("soc_mbox_data_avail", 1, soc_mbox_data_avail);
        check_value("uc_mbox_data_avail", 0, uc_mbox_data_avail);
        // every read, the first included, lands during a refill and waits one cycle
        for (int i = 0; i < 8; i++) begin
            reg_read(1'b1, 8'd3, mbox_pkg::REG_DATAOUT, rd, holds);
            check_value("dataout", words[i], rd);
            check_value("req_hold cycles", 1, holds);
        end
        reg_write(1'b1, 8'd3, mbox_pkg::REG_STATUS, mbox_pkg::CMD_COMPLETE);
        reg_read(1'b0, 8'd0, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status", status_word(mbox_pkg::MBOX_EXECUTE_SOC, 1'b0,
                                          mbox_pkg::CMD_COMPLETE), rd);
        reg_write(1'b0, 8'd0, mbox_pkg::REG_EXECUTE, 32'd0);
        wait_idle();
    endtask

    task automatic ownership_rules();
        logic [DATA_W-1:0] rd;
        int                holds;
        reg_read(1'b1, 8'd5, mbox_pkg::REG_LOCK, rd, holds);
        check_value("lock", 0, rd);
        reg_read(1'b1, 8'd5, mbox_pkg::REG_USER, rd, holds);
        check_value("user", 5, rd);
        reg_write(1'b1, 8'd5, mbox_pkg::REG_CMD, 32'h5500_0001);
        // neither the uc nor another soc user may touch a soc-owned mailbox
        reg_write(1'b0, 8'd0, mbox_pkg::REG_CMD, 32'hdead_0002);
        reg_write(1'b1, 8'd9, mbox_pkg::REG_CMD, 32'h9900_0003);
        reg_read(1'b1, 8'd5, mbox_pkg::REG_CMD, rd, holds);
        check_value("cmd", 32'h5500_0001, rd);
        reg_read(1'b1, 8'd5, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status", status_word(mbox_pkg::MBOX_RDY_FOR_DLEN, 1'b1,
                                          mbox_pkg::CMD_BUSY), rd);
        // dataout still holds a stale prefetch from the previous transfer
        reg_read(1'b1, 8'd5, mbox_pkg::REG_DATAOUT, rd, holds);
        check_value("dataout", 0, rd);
    endtask

    task automatic soc_to_uc_response();
        logic [DATA_W-1:0] words [6];
        logic [DATA_W-1:0] rd;
        int                holds;
        reg_write(1'b1, 8'd5, mbox_pkg::REG_DLEN, 32'd24);
        for (int i = 0; i < 6; i++) begin
            lcg_state = lcg_step(lcg_state);
            words[i] = lcg_state;
            reg_write(1'b1, 8'd5, mbox_pkg::REG_DATAIN, words[i]);
        end
        reg_write(1'b1, 8'd5, mbox_pkg::REG_EXECUTE, 32'd1);
        check_value("uc_mbox_data_avail", 1, uc_mbox_data_avail);
        check_value("soc_mbox_data_avail", 0, soc_mbox_data_avail);
        for (int i = 0; i < 6; i++) begin
            reg_read(1'b0, 8'd0, mbox_pkg::REG_DATAOUT, rd, holds);
            check_value("dataout", words[i], rd);
            check_value("req_hold cycles", 1, holds);
        end
        // the uc answers with two words and a completion status
        for (int i = 0; i < 2; i++) begin
            lcg_state = lcg_step(lcg_state);
            reg_write(1'b0, 8'd0, mbox_pkg::REG_DATAIN, lcg_state);
        end
        reg_write(1'b0, 8'd0, mbox_pkg::REG_STATUS, mbox_pkg::CMD_COMPLETE);
        reg_read(1'b1, 8'd5, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status", status_word(mbox_pkg::MBOX_EXECUTE_UC, 1'b1,
                                          mbox_pkg::CMD_COMPLETE), rd);
        reg_read(1'b1, 8'd5, mbox_pkg::REG_DATAOUT, rd, holds);
        check_value("dataout", 0, rd);
        reg_write(1'b1, 8'd5, mbox_pkg::REG_EXECUTE, 32'd0);
        wait_idle();
        reg_read(1'b0, 8'd0, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status", 0, rd);
        check_value("uc_mbox_data_avail", 0, uc_mbox_data_avail);
        check_value("soc_mbox_data_avail", 0, soc_mbox_data_avail);
        reg_read(1'b0, 8'd0, mbox_pkg::REG_LOCK, rd, holds);
        check_value("lock", 0, rd);
    endtask

    task automatic unlock_and_error();
        logic [DATA_W-1:0] rd;
        logic              err;
        int                holds;
        // the uc kept the lock from the previous test
        reg_write(1'b0, 8'd0, mbox_pkg::REG_CMD, 32'h0000_0077);
        reg_write(1'b0, 8'd0, mbox_pkg::REG_DLEN, 32'd8);
        reg_write(1'b0, 8'd0, mbox_pkg::REG_DATAIN, 32'h1234_5678);
        reg_write(1'b1, 8'd5, mbox_pkg::REG_UNLOCK, 32'd1);
        reg_read(1'b0, 8'd0, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status", status_word(mbox_pkg::MBOX_RDY_FOR_DATA, 1'b0,
                                          mbox_pkg::CMD_BUSY), rd);
        reg_write(1'b0, 8'd0, mbox_pkg::REG_UNLOCK, 32'd1);
        reg_read(1'b0, 8'd0, mbox_pkg::REG_STATUS, rd, holds);
        check_value("status.state", mbox_pkg::MBOX_IDLE, rd[mbox_pkg::STATUS_STATE_LSB +: 3]);
        bus_access(1'b0, 8'd0, 1'b1, 4'd12, 32'hffff_ffff, rd, err, holds);
        check_value("mbox_error", 1, err);
        bus_access(1'b0, 8'd0, 1'b0, 4'd12, '0, rd, err, holds);
        check_value("mbox_error", 1, err);
        check_value("rdata", 0, rd);
        bus_access(1'b0, 8'd0, 1'b0, mbox_pkg::REG_STATUS, '0, rd, err, holds);
        check_value("mbox_error", 0, err);
    endtask

    initial begin
        req_dv    = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_soc   = 1'b0;
        req_user  = '0;
        @(posedge rst_b);
        @(posedge clk);
        #2;
        reset_and_lock();
        uc_to_soc_transfer();
        ownership_rules();
        soc_to_uc_response();
        unlock_and_error();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
/* testbench clock and reset source for the mailbox; 40 ns clock, reset held
   low for the first ten rising edges */
module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_b
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release a little after the edge so no flop sees reset and clock together
    initial begin
        rst_b = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_b = 1'b1;
    end

endmodule

// ==== mbox_top.sv ====
/* mailbox top level, connects the register file, protocol FSM, data path and
   storage behind one register port shared by the uc and the soc */
module mbox_top #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 64,
    localparam int PTR_W = $clog2(DEPTH)
) (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            req_dv,
    input  logic                            req_write,
    input  logic [mbox_pkg::REG_ADDR_W-1:0] req_addr,
    input  logic [DATA_W-1:0]               req_wdata,
    input  logic                            req_soc,
    input  logic [mbox_pkg::USER_W-1:0]     req_user,
    output logic [DATA_W-1:0]               rdata,
    output logic                            req_hold,
    output logic                            mbox_error,
    output logic                            uc_mbox_data_avail,
    output logic                            soc_mbox_data_avail
);

    // register strobes into the FSM
    logic lock_rd;
    logic cmd_wr;
    logic dlen_wr;
    logic datain_wr;
    logic dataout_rd;
    logic execute_wr;
    logic unlock_wr;
    logic execute_val;
    logic dataout_sel;

    // FSM state and ownership back to the registers
    mbox_pkg::mbox_fsm_state_e   fsm_state;
    logic                        lock_val;
    logic                        soc_has_lock;
    logic [mbox_pkg::USER_W-1:0] owner_user;
    logic                        valid_user;
    logic                        lock_clr;
    logic                        read_mask;

    // pointer control and storage traffic
    logic              wr_inc;
    logic              rd_inc;
    logic              wrptr_clr;
    logic              rdptr_clr;
    logic [DATA_W-1:0] dataout;
    logic              sram_we;
    logic [PTR_W-1:0]  sram_waddr;
    logic [DATA_W-1:0] sram_wdata;
    logic              sram_re;
    logic [PTR_W-1:0]  sram_raddr;
    logic [DATA_W-1:0] sram_rdata;

    // status only leaves the mailbox through the status register read
    mbox_regs #(
        .DATA_W (DATA_W)
    ) i_mbox_regs (
        .*,
        .status_val ()
    );

    mbox_fsm i_mbox_fsm (.*);

    mbox_data_path #(
        .DATA_W (DATA_W),
        .DEPTH  (DEPTH)
    ) i_mbox_data_path (.*);

    mbox_sram #(
        .DATA_W (DATA_W),
        .DEPTH  (DEPTH)
    ) i_mbox_sram (
        .clk   (clk),
        .we    (sram_we),
        .waddr (sram_waddr),
        .wdata (sram_wdata),
        .re    (sram_re),
        .raddr (sram_raddr),
        .rdata (sram_rdata)
    );

endmodule

// ==== mbox_regs.sv ====
/* mailbox register file: decodes the shared register port, holds the software
   registers and builds the read data and error flag */
module mbox_regs #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            req_dv,
    input  logic                            req_write,
    input  logic [mbox_pkg::REG_ADDR_W-1:0] req_addr,
    input  logic [DATA_W-1:0]               req_wdata,
    input  mbox_pkg::mbox_fsm_state_e       fsm_state,
    input  logic                            lock_val,
    input  logic                            soc_has_lock,
    input  logic [mbox_pkg::USER_W-1:0]     owner_user,
    input  logic                            valid_user,
    input  logic                            lock_clr,
    input  logic                            read_mask,
    input  logic [DATA_W-1:0]               dataout,
    input  logic                            req_hold,
    output logic [DATA_W-1:0]               rdata,
    output logic                            mbox_error,
    output logic                            lock_rd,
    output logic                            cmd_wr,
    output logic                            dlen_wr,
    output logic                            datain_wr,
    output logic                            dataout_rd,
    output logic                            execute_wr,
    output logic                            unlock_wr,
    output logic                            execute_val,
    output mbox_pkg::mbox_status_e          status_val,
    output logic                            dataout_sel
);

    logic              acc_rd;
    logic              acc_wr;
    logic              exec_sel_wr;
    logic              status_sel_wr;
    logic [DATA_W-1:0] cmd_q;
    logic [DATA_W-1:0] dlen_q;
    logic [DATA_W-1:0] status_word;

    // an access only counts at the edge where it is not stalled
    assign acc_rd = req_dv & ~req_hold & ~req_write;
    assign acc_wr = req_dv & ~req_hold & req_write;

    assign lock_rd    = acc_rd & (req_addr == mbox_pkg::REG_LOCK);
    assign dataout_rd = acc_rd & (req_addr == mbox_pkg::REG_DATAOUT);
    assign cmd_wr     = acc_wr & (req_addr == mbox_pkg::REG_CMD);
    assign dlen_wr    = acc_wr & (req_addr == mbox_pkg::REG_DLEN);
    assign datain_wr  = acc_wr & (req_addr == mbox_pkg::REG_DATAIN);
    assign exec_sel_wr   = acc_wr & (req_addr == mbox_pkg::REG_EXECUTE);
    assign status_sel_wr = acc_wr & (req_addr == mbox_pkg::REG_STATUS);

    // the fsm only needs to see execute being set, clearing shows up on execute_val
    assign execute_wr = exec_sel_wr & req_wdata[0];
    // unlock is a write of 1, the fsm decides whether the uc sent it
    assign unlock_wr  = acc_wr & (req_addr == mbox_pkg::REG_UNLOCK) & req_wdata[0];

    // raw dataout decode, the data path turns this into the stall
    assign dataout_sel = req_dv & ~req_write & (req_addr == mbox_pkg::REG_DATAOUT);

    // offsets past the last register are not mapped
    assign mbox_error = req_dv & (req_addr > mbox_pkg::REG_UNLOCK);

    // software registers, only the current lock holder or receiver may change them
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cmd_q       <= '0;
            dlen_q      <= '0;
            execute_val <= 1'b0;
            status_val  <= mbox_pkg::CMD_BUSY;
        end else begin
            if (cmd_wr && valid_user) begin
                cmd_q <= req_wdata;
            end
            if (dlen_wr && valid_user) begin
                dlen_q <= req_wdata;
            end
            // releasing the lock wipes the handshake registers for the next owner
            if (lock_clr) begin
                execute_val <= 1'b0;
                status_val  <= mbox_pkg::CMD_BUSY;
            end else begin
                if (exec_sel_wr && valid_user) begin
                    execute_val <= req_wdata[0];
                end
                if (status_sel_wr && valid_user) begin
                    status_val <= mbox_pkg::mbox_status_e'(req_wdata[1:0]);
                end
            end
        end
    end

    // status word is status, then the state, then the soc ownership bit
    always_comb begin
        status_word = '0;
        status_word[1:0] = status_val;
        status_word[mbox_pkg::STATUS_STATE_LSB +: 3] = fsm_state;
        status_word[mbox_pkg::STATUS_STATE_LSB + 3] = soc_has_lock;
    end

    always_comb begin
        rdata = '0;
        case (req_addr)
            mbox_pkg::REG_LOCK:    rdata[0] = lock_val;
            mbox_pkg::REG_USER:    rdata[mbox_pkg::USER_W-1:0] = owner_user;
            mbox_pkg::REG_CMD:     rdata = cmd_q;
            mbox_pkg::REG_DLEN:    rdata = dlen_q;
            // a requester that is not the receiver sees zeros instead of the payload
            mbox_pkg::REG_DATAOUT: rdata = read_mask ? '0 : dataout;
            mbox_pkg::REG_EXECUTE: rdata[0] = execute_val;
            mbox_pkg::REG_STATUS:  rdata = status_word;
            default:               rdata = '0;
        endcase
    end

    // a stalled read stays on the bus unchanged, so no write can take its place
    a_no_write_in_hold: assert property (@(posedge clk) disable iff (!rst_b)
        req_hold |=> req_dv && !req_write && $stable(req_addr));

endmodule

// ==== mbox_fsm.sv ====
/* mailbox protocol FSM: tracks the lock and its owner, checks each request
   against the owner and steps the storage pointers */
module mbox_fsm (
    input  logic                        clk,
    input  logic                        rst_b,
    input  logic                        req_soc,
    input  logic [mbox_pkg::USER_W-1:0] req_user,
    input  logic                        lock_rd,
    input  logic                        cmd_wr,
    input  logic                        dlen_wr,
    input  logic                        datain_wr,
    input  logic                        dataout_rd,
    input  logic                        execute_wr,
    input  logic                        unlock_wr,
    input  logic                        execute_val,
    output mbox_pkg::mbox_fsm_state_e   fsm_state,
    output logic                        lock_val,
    output logic                        soc_has_lock,
    output logic [mbox_pkg::USER_W-1:0] owner_user,
    output logic                        valid_user,
    output logic                        lock_clr,
    output logic                        read_mask,
    output logic                        wr_inc,
    output logic                        rd_inc,
    output logic                        wrptr_clr,
    output logic                        rdptr_clr,
    output logic                        uc_mbox_data_avail,
    output logic                        soc_mbox_data_avail
);

    mbox_pkg::mbox_fsm_state_e state_d;
    logic lock_acq;
    logic force_unlock;
    logic receiver;

    // reading the lock while it is clear takes it
    assign lock_acq = lock_rd & ~lock_val;
    // only the uc can force the mailbox back to idle
    assign force_unlock = unlock_wr & ~req_soc;

    // uc is valid while it holds the lock or is the receiver, the soc needs a user match
    assign valid_user = ~req_soc & ((lock_val & ~soc_has_lock) |
                                    (fsm_state == mbox_pkg::MBOX_EXECUTE_UC)) |
                        req_soc & ((lock_val & soc_has_lock & (req_user == owner_user)) |
                                   (fsm_state == mbox_pkg::MBOX_EXECUTE_SOC));

    // the receiver is whoever the data was sent to
    assign receiver = (fsm_state == mbox_pkg::MBOX_EXECUTE_UC & ~req_soc) |
                      (fsm_state == mbox_pkg::MBOX_EXECUTE_SOC & req_soc);
    assign read_mask = ~receiver;

    assign uc_mbox_data_avail  = (fsm_state == mbox_pkg::MBOX_EXECUTE_UC);
    assign soc_mbox_data_avail = (fsm_state == mbox_pkg::MBOX_EXECUTE_SOC);

    always_comb begin
        state_d   = fsm_state;
        lock_clr  = 1'b0;
        wr_inc    = 1'b0;
        rd_inc    = 1'b0;
        wrptr_clr = 1'b0;
        rdptr_clr = 1'b0;
        case (fsm_state)
            mbox_pkg::MBOX_IDLE: begin
                if (lock_acq) begin
                    state_d = mbox_pkg::MBOX_RDY_FOR_CMD;
                end
            end
            mbox_pkg::MBOX_RDY_FOR_CMD: begin
                if (cmd_wr && valid_user) begin
                    state_d = mbox_pkg::MBOX_RDY_FOR_DLEN;
                end
            end
            mbox_pkg::MBOX_RDY_FOR_DLEN: begin
                if (dlen_wr && valid_user) begin
                    state_d = mbox_pkg::MBOX_RDY_FOR_DATA;
                end
            end
            mbox_pkg::MBOX_RDY_FOR_DATA: begin
                wr_inc = datain_wr & valid_user;
                if (execute_wr && valid_user) begin
                    // data goes to the side that did not lock the mailbox
                    state_d = soc_has_lock ? mbox_pkg::MBOX_EXECUTE_UC
                                           : mbox_pkg::MBOX_EXECUTE_SOC;
                    // rewind writes for the response and prefetch entry 0
                    wrptr_clr = 1'b1;
                    rd_inc    = 1'b1;
                end
            end
            mbox_pkg::MBOX_EXECUTE_UC, mbox_pkg::MBOX_EXECUTE_SOC: begin
                if (!execute_val) begin
                    state_d   = mbox_pkg::MBOX_IDLE;
                    lock_clr  = 1'b1;
                    wrptr_clr = 1'b1;
                    rdptr_clr = 1'b1;
                end else begin
                    wr_inc = datain_wr & receiver;
                    rd_inc = dataout_rd & receiver;
                end
            end
            default: begin
                state_d = mbox_pkg::MBOX_IDLE;
            end
        endcase
        // forced unlock wins over whatever the state was doing
        if (force_unlock) begin
            state_d   = mbox_pkg::MBOX_IDLE;
            lock_clr  = 1'b1;
            wrptr_clr = 1'b1;
            rdptr_clr = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            fsm_state    <= mbox_pkg::MBOX_IDLE;
            lock_val     <= 1'b0;
            soc_has_lock <= 1'b0;
            owner_user   <= '0;
        end else begin
            fsm_state <= state_d;
            // remember who took the lock so later requests can be checked
            if (lock_acq) begin
                lock_val     <= 1'b1;
                soc_has_lock <= req_soc;
                owner_user   <= req_user;
            end else if (lock_clr) begin
                lock_val     <= 1'b0;
                soc_has_lock <= 1'b0;
            end
        end
    end

    // the state stays in the enum, and every state past idle belongs to a lock holder
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_b)
        (fsm_state <= mbox_pkg::MBOX_EXECUTE_SOC) &&
        ((fsm_state == mbox_pkg::MBOX_IDLE) || lock_val));

    a_wr_inc_clr_excl: assert property (@(posedge clk) disable iff (!rst_b)
        !(wr_inc && wrptr_clr));

endmodule

// ==== mbox_data_path.sv ====
/* mailbox data path: write and read pointers into storage, the dataout
   prefetch register and the stall for a read that beats the refill */
module mbox_data_path #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 64,
    localparam int PTR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst_b,
    input  logic              wr_inc,
    input  logic              rd_inc,
    input  logic              wrptr_clr,
    input  logic              rdptr_clr,
    input  logic [DATA_W-1:0] req_wdata,
    input  logic              dataout_sel,
    input  logic [DATA_W-1:0] sram_rdata,
    output logic              sram_we,
    output logic [PTR_W-1:0]  sram_waddr,
    output logic [DATA_W-1:0] sram_wdata,
    output logic              sram_re,
    output logic [PTR_W-1:0]  sram_raddr,
    output logic [DATA_W-1:0] dataout,
    output logic              req_hold
);

    logic [PTR_W-1:0] wrptr;
    logic [PTR_W-1:0] rdptr;
    logic             refill;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wrptr  <= '0;
            rdptr  <= '0;
            refill <= 1'b0;
        end else begin
            if (wrptr_clr) begin
                wrptr <= '0;
            end else if (wr_inc) begin
                wrptr <= wrptr + 1'b1;
            end
            if (rdptr_clr) begin
                rdptr <= '0;
            end else if (rd_inc) begin
                rdptr <= rdptr + 1'b1;
            end
            // storage data arrives one cycle after the read is launched
            refill <= rd_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            dataout <= sram_rdata;
        end
    end

    assign sram_we    = wr_inc;
    assign sram_waddr = wrptr;
    assign sram_wdata = req_wdata;
    assign sram_re    = rd_inc;
    assign sram_raddr = rdptr;

    // a dataout read during the refill would see the stale word, so hold it
    assign req_hold = dataout_sel & refill;

    a_no_inc_in_refill: assert property (@(posedge clk) disable iff (!rst_b)
        refill |-> !rd_inc);

endmodule

// ==== mbox_sram.sv ====
/* mailbox storage, one write port and one read port with registered read data */
module mbox_sram #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 64,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // read data holds until the next read
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== mbox_pkg.sv ====
/* shared types and widths for the mailbox; every mailbox module and the testbench
   refer to them by scoped name */
package mbox_pkg;

    // register offsets are word offsets within the mailbox window
    localparam int REG_ADDR_W = 4;
    localparam int USER_W = 8;
    // the state field of the status word starts above the two status bits
    localparam int STATUS_STATE_LSB = 2;

    // protocol states, in the order a requester walks through them
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'd0,
        MBOX_RDY_FOR_CMD  = 3'd1,
        MBOX_RDY_FOR_DLEN = 3'd2,
        MBOX_RDY_FOR_DATA = 3'd3,
        MBOX_EXECUTE_UC   = 3'd4,
        MBOX_EXECUTE_SOC  = 3'd5
    } mbox_fsm_state_e;

    // command status written by the receiver
    typedef enum logic [1:0] {
        CMD_BUSY     = 2'd0,
        DATA_READY   = 2'd1,
        CMD_COMPLETE = 2'd2,
        CMD_FAILURE  = 2'd3
    } mbox_status_e;

    // anything above REG_UNLOCK is unmapped and raises the error flag
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_LOCK    = 4'd0,
        REG_USER    = 4'd1,
        REG_CMD     = 4'd2,
        REG_DLEN    = 4'd3,
        REG_DATAIN  = 4'd4,
        REG_DATAOUT = 4'd5,
        REG_EXECUTE = 4'd6,
        REG_STATUS  = 4'd7,
        REG_UNLOCK  = 4'd8
    } mbox_reg_e;

endpackage
